// ==== Makefile ====
SRCS := $(shell cat vlog.f)

obj_dir/VprocessingTb: vlog.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/10ps -j 0 \
		--top-module processingTb -f vlog.f

run: obj_dir/VprocessingTb
	@result="$$(./obj_dir/VprocessingTb)"; \
	echo "$$result"; \
	echo "$$result" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== colorMatrix.sv ====
`timescale 1ns/10ps

module colorMatrix (
	input logic clk,
	input logic reset,
	pixelStream.sink in,
	pixelStream.source out,
	output pixelPkg::yccPixel_t yccOut
);
	import pixelPkg::*;

	logic [7:0] chan [3];

	// Stage one holds the products and the carried pixel
	logic s1Valid;
	logic signed [26:0] prod [9];
	rgbPixel_t s1Rgb;
	logic s1Sof;
	logic s1Eol;

	// Stage two holds the finished conversion
	logic s2Valid;
	yccPixel_t s2Ycc;
	rgbPixel_t s2Rgb;
	logic s2Sof;
	logic s2Eol;

	logic signed [29:0] rowSum [3];
	logic signed [31:0] rowScaled [3];
	logic [7:0] rowByte [3];

	logic adv1;
	logic adv2;

	function automatic logic [7:0] clampByte(input logic signed [31:0] value);
		if (value < 0) begin
			return 8'd0;
		end else if (value > 255) begin
			return 8'd255;
		end
		return value[7:0];
	endfunction

	assign chan[0] = in.data.r;
	assign chan[1] = in.data.g;
	assign chan[2] = in.data.b;

	assign adv2 = !s2Valid || out.ready;
	assign adv1 = !s1Valid || adv2;
	assign in.ready = adv1;

	always_ff @(posedge clk) begin
		if (reset) begin
			s1Valid <= 1'b0;
			s2Valid <= 1'b0;
		end else begin
			if (adv1) begin
				s1Valid <= in.valid;
			end
			if (adv2) begin
				s2Valid <= s1Valid;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (adv1 && in.valid) begin
			for (int k = 0; k < 9; k++) begin
				prod[k] <= rgb2yccCoef[k] * $signed({1'b0, chan[k % 3]});
			end
			s1Rgb <= in.data;
			s1Sof <= in.sof;
			s1Eol <= in.eol;
		end
	end

	// Row sums with half an LSB for rounding, then back to integer scale
	always_comb begin
		for (int row = 0; row < 3; row++) begin
			rowSum[row] = prod[3*row] + prod[3*row+1] + prod[3*row+2] + 30'sd32768;
			rowScaled[row] = (rowSum[row] >>> coefFracBits) + ((row == 0) ? 0 : chromaOffset);
			rowByte[row] = clampByte(rowScaled[row]);
		end
	end

	always_ff @(posedge clk) begin
		if (adv2 && s1Valid) begin
			s2Ycc.y <= rowByte[0];
			s2Ycc.cb <= rowByte[1];
			s2Ycc.cr <= rowByte[2];
			s2Rgb <= s1Rgb;
			s2Sof <= s1Sof;
			s2Eol <= s1Eol;
		end
	end

	assign out.valid = s2Valid;
	assign out.data = s2Rgb;
	assign out.sof = s2Sof;
	assign out.eol = s2Eol;
	assign yccOut = s2Ycc;

endmodule

// ==== lineFilter.sv ====
`timescale 1ns/10ps

module lineFilter #(
	parameter int lineWidth = 6
) (
	input logic clk,
	input logic reset,
	pixelStream.sink in,
	pixelStream.source out
);
	import pixelPkg::*;

	localparam int colBits = $clog2(lineWidth + 1);

	// Sliding window where prev is the left neighbor of cur
	rgbPixel_t prev;
	rgbPixel_t cur;
	logic curSof;
	logic curValid;
	logic [colBits-1:0] colCount;

	// Set after an eol pixel while the last pixel still waits in cur
	logic flush;

	rgbPixel_t leftPix;
	logic outAdvance;
	logic accept;

	logic outValidReg;
	rgbPixel_t outPixel;
	logic outSofReg;
	logic outEolReg;

	// One channel of [1 2 1]/4 with rounding
	function automatic logic [7:0] tap(
		input logic [7:0] a,
		input logic [7:0] b,
		input logic [7:0] c
	);
		logic [9:0] sum;
		sum = {2'b00, a} + {1'b0, b, 1'b0} + {2'b00, c} + 10'd2;
		return sum[9:2];
	endfunction

	function automatic rgbPixel_t smooth(
		input rgbPixel_t left,
		input rgbPixel_t center,
		input rgbPixel_t right
	);
		rgbPixel_t result;
		result.r = tap(left.r, center.r, right.r);
		result.g = tap(left.g, center.g, right.g);
		result.b = tap(left.b, center.b, right.b);
		return result;
	endfunction

	// Cur is the first pixel of its line when only one pixel has come in
	assign leftPix = (colCount > colBits'(1)) ? prev : '0;

	assign outAdvance = !outValidReg || out.ready;
	assign in.ready = outAdvance && !flush;
	assign accept = in.valid && in.ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			outValidReg <= 1'b0;
			curValid <= 1'b0;
			flush <= 1'b0;
			colCount <= '0;
		end else begin
			if (outAdvance) begin
				if (flush) begin
					// Right neighbor of the last pixel is padding
					outValidReg <= 1'b1;
					flush <= 1'b0;
					curValid <= 1'b0;
					colCount <= '0;
				end else if (accept && curValid) begin
					outValidReg <= 1'b1;
				end else begin
					outValidReg <= 1'b0;
				end
			end
			if (accept) begin
				curValid <= 1'b1;
				flush <= in.eol;
				if (in.sof) begin
					colCount <= colBits'(1);
				end else if (colCount != colBits'(lineWidth)) begin
					colCount <= colCount + colBits'(1);
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (outAdvance && flush) begin
			outPixel <= smooth(leftPix, cur, '0);
			outSofReg <= curSof;
			outEolReg <= 1'b1;
		end else if (accept && curValid) begin
			outPixel <= smooth(leftPix, cur, in.data);
			outSofReg <= curSof;
			outEolReg <= 1'b0;
		end
		if (accept) begin
			prev <= cur;
			cur <= in.data;
			curSof <= in.sof;
		end
	end

	assign out.valid = outValidReg;
	assign out.data = outPixel;
	assign out.sof = outSofReg;
	assign out.eol = outEolReg;

endmodule

// ==== pixelOutput.sv ====
`timescale 1ns/10ps

module pixelOutput #(
	parameter int frameHeight = 3
) (
	input logic clk,
	input logic reset,
	input logic yccMode,
	input pixelPkg::yccPixel_t ycc,
	pixelStream.sink in,
	output logic outValid,
	output logic outSof,
	output logic outEol,
	output logic outFrameEnd,
	output pixelPkg::pixelWord_t outData,
	input logic outReady
);
	import pixelPkg::*;

	localparam int lineBits = (frameHeight > 1) ? $clog2(frameHeight + 1) : 1;

	// Mode latched with the sof pixel of the frame in flight
	logic frameMode;
	logic activeMode;
	logic [lineBits-1:0] lineCount;
	logic [lineBits-1:0] lineBase;
	logic advance;
	logic accept;
	pixelWord_t nextWord;

	assign advance = !outValid || outReady;
	assign in.ready = advance;
	assign accept = in.valid && advance;

	assign activeMode = in.sof ? yccMode : frameMode;
	assign lineBase = in.sof ? '0 : lineCount;

	always_comb begin
		if (activeMode) begin
			nextWord.ycc = ycc;
		end else begin
			nextWord.rgb = in.data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			outValid <= 1'b0;
			outFrameEnd <= 1'b0;
			frameMode <= 1'b0;
			lineCount <= '0;
		end else if (advance) begin
			outValid <= in.valid;
			if (accept) begin
				frameMode <= activeMode;
				lineCount <= in.eol ? lineBase + lineBits'(1) : lineBase;
				// Frame ends with the eol that completes the last line
				outFrameEnd <= in.eol && (lineBase == lineBits'(frameHeight - 1));
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			outData <= nextWord;
			outSof <= in.sof;
			outEol <= in.eol;
		end
	end

endmodule

// ==== pixelPkg.sv ====
package pixelPkg;

	// Pixel as it enters the chain and as the smoothing filter leaves it
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgbPixel_t;

	// Luma first, then the two chroma channels
	typedef struct packed {
		logic [7:0] y;
		logic [7:0] cb;
		logic [7:0] cr;
	} yccPixel_t;

	// Output word read as RGB or YCbCr depending on the frame mode
	typedef union packed {
		rgbPixel_t rgb;
		yccPixel_t ycc;
	} pixelWord_t;

	// Coefficients are scaled by 2^coefFracBits
	localparam int coefFracBits = 16;

	// BT.601 full range coefficients in rows Y, Cb, Cr and columns R, G, B
	localparam logic signed [17:0] rgb2yccCoef [9] = '{
		18'sd19595,
		18'sd38470,
		18'sd7471,
		-18'sd11059,
		-18'sd21709,
		18'sd32768,
		18'sd32768,
		-18'sd27439,
		-18'sd5329
	};

	// Chroma is centred on mid scale
	localparam int chromaOffset = 128;

endpackage

// ==== pixelStream.sv ====
`timescale 1ns/10ps

interface pixelStream;
	import pixelPkg::*;

	logic valid;
	logic ready;
	rgbPixel_t data;
	logic sof;
	logic eol;

	modport source (
		output valid,
		output data,
		output sof,
		output eol,
		input ready
	);

	modport sink (
		input valid,
		input data,
		input sof,
		input eol,
		output ready
	);

endinterface

// ==== processing.sv ====
`timescale 1ns/10ps

module processing #(
	parameter int lineWidth = 6,
	parameter int frameHeight = 3
) (
	input logic clk,
	input logic reset,

	// Pixel input
	input logic inValid,
	input pixelPkg::rgbPixel_t inData,
	input logic inSof,
	input logic inEol,
	input logic yccMode,
	output logic inReady,

	// Result output
	output logic outValid,
	output pixelPkg::pixelWord_t outData,
	output logic outSof,
	output logic outEol,
	output logic outFrameEnd,
	input logic outReady
);
	import pixelPkg::*;

	pixelStream inLink ();
	pixelStream filtLink ();
	pixelStream matLink ();

	// YCbCr result travels beside matLink
	yccPixel_t matYcc;

	assign inLink.valid = inValid;
	assign inLink.data = inData;
	assign inLink.sof = inSof;
	assign inLink.eol = inEol;
	assign inReady = inLink.ready;

	lineFilter #(.lineWidth(lineWidth)) filterStage (
		.clk(clk),
		.reset(reset),
		.in(inLink.sink),
		.out(filtLink.source)
	);

	colorMatrix matrixStage (
		.clk(clk),
		.reset(reset),
		.in(filtLink.sink),
		.out(matLink.source),
		.yccOut(matYcc)
	);

	pixelOutput #(.frameHeight(frameHeight)) outputStage (
		.clk(clk),
		.reset(reset),
		.yccMode(yccMode),
		.ycc(matYcc),
		.in(matLink.sink),
		.outValid(outValid),
		.outSof(outSof),
		.outEol(outEol),
		.outFrameEnd(outFrameEnd),
		.outData(outData),
		.outReady(outReady)
	);

endmodule

// ==== processingTb.sv ====
`timescale 1ns/10ps

module processingTb;
	import pixelPkg::*;

	localparam int lineWidth = 6;
	localparam int frameHeight = 3;
	localparam int framePixels = lineWidth * frameHeight;
	localparam int pixelCount = 2 * framePixels;
	localparam int cycleLimit = 8 * pixelCount + 100;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic inValid = 1'b0;
	rgbPixel_t inData = '0;
	logic inSof = 1'b0;
	logic inEol = 1'b0;
	logic yccMode = 1'b0;
	logic outReady = 1'b0;
	logic inReady;
	logic outValid;
	pixelWord_t outData;
	logic outSof;
	logic outEol;
	logic outFrameEnd;

	// Entries packed as {pixel, sof, eol, mode} and {word, sof, eol, frameEnd}
	logic [26:0] stimEntry [pixelCount];
	logic [26:0] expEntry [pixelCount];

	int outIndex = 0;
	int errorCount = 0;
	int testErrors [2] = '{0, 0};
	int cycleCount = 0;
	logic [31:0] randState = 32'he67d;

	processing #(.lineWidth(lineWidth), .frameHeight(frameHeight)) DUT (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inData(inData),
		.inSof(inSof),
		.inEol(inEol),
		.yccMode(yccMode),
		.inReady(inReady),
		.outValid(outValid),
		.outData(outData),
		.outSof(outSof),
		.outEol(outEol),
		.outFrameEnd(outFrameEnd),
		.outReady(outReady)
	);

	bind processing processingAsserts #(.lineWidth(lineWidth)) handshakeChecks (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inReady(inReady),
		.inEol(inEol),
		.outValid(outValid),
		.outReady(outReady),
		.outData(outData)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] nextRandom(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	// Two header lines, then the input section and the expected section
	function automatic bit loadTrace();
		int fd;
		int status;
		string header;
		logic [23:0] word;
		logic flagA;
		logic flagB;
		logic flagC;
		fd = $fopen("processing_trace.txt", "r");
		if (fd == 0) begin
			return 1'b0;
		end
		status = $fgets(header, fd);
		status = $fgets(header, fd);
		for (int i = 0; i < 2 * pixelCount; i++) begin
			status = $fscanf(fd, "%h %h %h %h", word, flagA, flagB, flagC);
			if (status != 4) begin
				$fclose(fd);
				return 1'b0;
			end
			if (i < pixelCount) begin
				stimEntry[i] = {word, flagA, flagB, flagC};
			end else begin
				expEntry[i - pixelCount] = {word, flagA, flagB, flagC};
			end
		end
		$fclose(fd);
		return 1'b1;
	endfunction

	task automatic reportMismatch(input string name, input logic [23:0] got,
		input logic [23:0] want, input int frame);
		$display("FAILED at %0t: %s is %h, expected %h", $time, name, got, want);
		errorCount++;
		testErrors[frame]++;
	endtask

	task automatic checkOutput();
		logic [26:0] want;
		int frame;
		want = expEntry[outIndex];
		frame = outIndex / framePixels;
		// The frame mode tells how the output word is decoded
		assert (outData == want[26:3]) else begin
			reportMismatch(stimEntry[outIndex][0] ? "outData.ycc" : "outData.rgb",
				outData, want[26:3], frame);
		end
		assert (outSof == want[2]) else begin
			reportMismatch("outSof", 24'(outSof), 24'(want[2]), frame);
		end
		assert (outEol == want[1]) else begin
			reportMismatch("outEol", 24'(outEol), 24'(want[1]), frame);
		end
		assert (outFrameEnd == want[0]) else begin
			reportMismatch("outFrameEnd", 24'(outFrameEnd), 24'(want[0]), frame);
		end
		outIndex++;
		if (outIndex % framePixels == 0) begin
			$display("Test %0d (%s): %0d outputs checked, %0d errors", frame + 1,
				(frame == 0) ? "RGB smoothing" : "YCbCr conversion",
				framePixels, testErrors[frame]);
		end
	endtask

	// Each pixel stays on the inputs until the DUT takes it
	task automatic sendPixels();
		for (int i = 0; i < pixelCount; i++) begin
			inValid <= 1'b1;
			inData <= stimEntry[i][26:3];
			inSof <= stimEntry[i][2];
			inEol <= stimEntry[i][1];
			yccMode <= stimEntry[i][0];
			@(posedge clk);
			while (!inReady) begin
				@(posedge clk);
			end
		end
		inValid <= 1'b0;
		inSof <= 1'b0;
		inEol <= 1'b0;
	endtask

	// Output checks, random back-pressure and the cycle limit
	always @(posedge clk) begin
		if (!reset) begin
			if (outValid && outReady) begin
				if (outIndex < pixelCount) begin
					checkOutput();
				end else begin
					$display("Output at %0t arrived after the last expected pixel", $time);
					errorCount++;
				end
			end
			randState = nextRandom(randState);
			outReady <= (randState[17:16] != 2'b00);
			cycleCount++;
			if (cycleCount >= cycleLimit) begin
				$display("Timeout after %0d cycles, %0d of %0d outputs received",
					cycleCount, outIndex, pixelCount);
				$display("Finished with errors");
				$finish;
			end
		end
	end

	initial begin
		if (!loadTrace()) begin
			$display("Could not read the trace file processing_trace.txt");
			$display("Finished with errors");
			$finish;
		end else begin
			repeat (2) @(posedge clk);
			reset <= 1'b0;
			sendPixels();
			while (outIndex < pixelCount) begin
				@(posedge clk);
			end
			// A few idle cycles catch any extra output
			repeat (4) @(posedge clk);
			$display("Checked %0d of %0d outputs: %0d errors (RGB %0d, YCbCr %0d)",
				outIndex, pixelCount, errorCount, testErrors[0], testErrors[1]);
			if (errorCount == 0) begin
				$display("Finished with no errors");
			end else begin
				$display("Finished with errors");
			end
			$finish;
		end
	end

endmodule

// ==== processing_asserts.sv ====
`timescale 1ns/10ps

module processingAsserts #(
	parameter int lineWidth = 6
) (
	input logic clk,
	input logic reset,
	input logic inValid,
	input logic inReady,
	input logic inEol,
	input logic outValid,
	input logic outReady,
	input pixelPkg::pixelWord_t outData
);
	localparam int colBits = $clog2(lineWidth + 1);

	// Pixels taken so far in the current input line
	logic [colBits-1:0] inColumn;

	always_ff @(posedge clk) begin
		if (reset) begin
			inColumn <= '0;
		end else if (inValid && inReady) begin
			inColumn <= inEol ? '0 : inColumn + colBits'(1);
		end
	end

	outputHolds: assert property (@(posedge clk) disable iff (reset)
		outValid && !outReady |=> outValid && $stable(outData))
		else $error("Output changed while the sink stalled");

	idleAfterReset: assert property (@(posedge clk) $past(reset) |-> !outValid)
		else $error("Output valid right after reset");

	lineLength: assert property (@(posedge clk) disable iff (reset)
		inValid && inReady && inEol |-> inColumn == colBits'(lineWidth - 1))
		else $error("End of line does not match the line width");

endmodule

// ==== processing_trace.txt ====
# Inputs: rrggbb sof eol yccMode, one image line per row, two frames of 6 x 3
# Then the expected outputs: outData sof eol frameEnd, in the same layout
0aff64 1 0 0  14ff00 0 0 0  1eff64 0 0 0  28ff00 0 0 0  32ff64 0 0 0  3cff00 0 1 0
000180 0 0 0  000280 0 0 0  000380 0 0 0  ff0480 0 0 0  000580 0 0 0  000680 0 1 0
c80003 0 0 0  c80007 0 0 0  c8000b 0 0 0  c8000f 0 0 0  c80013 0 0 0  c80017 0 1 0
646464 1 0 1  646464 0 0 1  646464 0 0 1  646464 0 0 1  646464 0 0 1  646464 0 1 1
0000ff 0 0 1  0000ff 0 0 1  0000ff 0 0 1  0000ff 0 0 1  0000ff 0 0 1  0000ff 0 1 1
ff0000 0 0 1  ff0000 0 0 1  ff0000 0 0 1  ff0000 0 0 1  ff0000 0 0 1  ff0000 0 1 1

0abf32 1 0 0  14ff32 0 0 0  1eff32 0 0 0  28ff32 0 0 0  32ff32 0 0 0  2bbf19 0 1 0
000160 0 0 0  000280 0 0 0  400380 0 0 0  800480 0 0 0  400580 0 0 0  000460 0 1 0
960003 0 0 0  c80007 0 0 0  c8000b 0 0 0  c8000f 0 0 0  c80013 0 0 0  960010 0 1 1
4b8080 1 0 0  648080 0 0 0  648080 0 0 0  648080 0 0 0  648080 0 0 0  4b8080 0 1 0
16e070 0 0 0  1dff6b 0 0 0  1dff6b 0 0 0  1dff6b 0 0 0  1dff6b 0 0 0  16e070 0 1 0
3960e0 0 0 0  4c55ff 0 0 0  4c55ff 0 0 0  4c55ff 0 0 0  4c55ff 0 0 0  3960e0 0 1 1

// ==== vlog.f ====
pixelPkg.sv
pixelStream.sv
lineFilter.sv
colorMatrix.sv
pixelOutput.sv
processing.sv
processing_asserts.sv
processingTb.sv
